//--- Bender.yml
package:
  name: mips_core

sources:
  - common/isaPkg.sv
  - common/uarchPkg.sv
  - rtl/alu.sv
  - rtl/registerFile.sv
  - rtl/busMaster.sv
  - control/controlUnit.sv
  - rtl/mipsCore.sv
  - target: simulation
    files:
      - bench/wbMemory.sv
      - bench/mipsCoreTb.sv

//--- bench/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;

	localparam int resetCycles = 16;
	localparam int words = uarchPkg::memBytes / 4;
	localparam int dataBase = uarchPkg::memBytes / 2; // Stores land in upper half
	localparam int topBit = uarchPkg::addrWidth - 1; // Set for data region
	localparam isaPkg::functT rOps [13] = '{isaPkg::fnAdd, isaPkg::fnAddu, isaPkg::fnSub,
		isaPkg::fnSubu, isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnNor, isaPkg::fnXor,
		isaPkg::fnSlt, isaPkg::fnSltu, isaPkg::fnSllv, isaPkg::fnSrlv, isaPkg::fnSrav};
	localparam isaPkg::opcodeT iOps [8] = '{isaPkg::opAddi, isaPkg::opAddiu,
		isaPkg::opSlti, isaPkg::opSltiu, isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori,
		isaPkg::opLui};

	logic CLK;
	logic reset;
	logic resetSeen = 1'b1; // Reset one cycle ago
	logic [1:0] waitCycles; // Ack delay for the memory
	uarchPkg::wbReqT wbReq;
	uarchPkg::wbRspT wbRsp;
	logic [31:0] rngState;
	logic [31:0] progWords [$];
	logic [31:0] expWord [words]; // Reference store image
	logic expValid [words];
	logic [uarchPkg::addrWidth-3:0] storeIdx;
	logic [31:0] expNow;
	logic expNowValid;
	int numStores = 0;
	int storesSeen = 0;
	int cycleCount = 0;
	int cycleLimit = 0; // Set once the program is built
	uarchPkg::addrT nextFetch; // Expected next fetch address
	uarchPkg::addrT prevAdr;
	logic prevWe;
	isaPkg::wordT prevDatW;

	mipsCore i_mipsCore (.CLK(CLK), .reset(reset), .wbReq(wbReq), .wbRsp(wbRsp));

	wbMemory i_wbMemory (
		.CLK(CLK),
		.reset(reset),
		.waitCycles(waitCycles),
		.wbReq(wbReq),
		.wbRsp(wbRsp)
	);

	assign storeIdx = wbReq.adr[topBit:2];
	assign expNow = expWord[storeIdx];
	assign expNowValid = expValid[storeIdx];

	//////////////////////////////////////////////////////////////////////
	// Random source, encoders and reference model
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic drawWord(output logic [31:0] w);
		rngState = lcgNext(rngState);
		w[31:16] = rngState[31:16]; // Upper bits, longer period
		rngState = lcgNext(rngState);
		w[15:0] = rngState[31:16];
	endtask

	function automatic logic [31:0] encR(input isaPkg::functT fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd);
		return {6'b000000, rs, rt, rd, 5'b00000, fn};
	endfunction

	function automatic logic [31:0] encI(input isaPkg::opcodeT op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] refR(input isaPkg::functT fn, input logic [31:0] s,
		input logic [31:0] t);
		logic signed [31:0] ts;
		ts = t;
		case (fn)
			isaPkg::fnAdd, isaPkg::fnAddu: return s + t; // No trap modelled
			isaPkg::fnSub, isaPkg::fnSubu: return s - t;
			isaPkg::fnAnd: return s & t;
			isaPkg::fnOr: return s | t;
			isaPkg::fnNor: return ~(s | t);
			isaPkg::fnXor: return s ^ t;
			isaPkg::fnSlt: return {31'b0, $signed(s) < $signed(t)};
			isaPkg::fnSltu: return {31'b0, s < t};
			isaPkg::fnSllv: return t << s[4:0]; // rt shifted by rs
			isaPkg::fnSrlv: return t >> s[4:0];
			isaPkg::fnSrav: return ts >>> s[4:0];
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [31:0] refI(input isaPkg::opcodeT op, input logic [31:0] s,
		input logic [15:0] imm);
		logic [31:0] se;
		logic [31:0] ze;
		se = {{16{imm[15]}}, imm};
		ze = {16'b0, imm};
		case (op)
			isaPkg::opAddi, isaPkg::opAddiu: return s + se;
			isaPkg::opSlti: return {31'b0, $signed(s) < $signed(se)};
			isaPkg::opSltiu: return {31'b0, s < se}; // Sign-extended, unsigned compare
			isaPkg::opAndi: return s & ze;
			isaPkg::opOri: return s | ze;
			isaPkg::opXori: return s ^ ze;
			isaPkg::opLui: return {imm, 16'b0};
			default: return 32'h0;
		endcase
	endfunction

	task automatic emit(input logic [31:0] w);
		progWords.push_back(w);
	endtask

	// SW rt to the next free data word, with its expected value
	task automatic storeReg(input logic [4:0] rt, input logic [31:0] value);
		int addr;
		addr = dataBase + 4 * numStores;
		emit(encI(isaPkg::opSw, 5'd0, rt, 16'(addr)));
		expWord[addr / 4] = value;
		expValid[addr / 4] = 1'b1;
		numStores++;
	endtask

	task automatic abortRun();
		$display("TESTBENCH FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Clock, program build and run
	//////////////////////////////////////////////////////////////////////

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	initial begin
		logic [31:0] c1;
		logic [31:0] c2;
		logic [31:0] w;
		reset = 1'b1;
		waitCycles = 2'd0;
		rngState = 32'd29184;
		for (int i = 0; i < words; i++) begin
			expWord[i] = 32'h0;
			expValid[i] = 1'b0;
		end
		drawWord(c1);
		drawWord(c2);
		emit(encI(isaPkg::opLui, 5'd0, 5'd1, c1[31:16])); // r1 = c1
		emit(encI(isaPkg::opOri, 5'd1, 5'd1, c1[15:0]));
		emit(encI(isaPkg::opLui, 5'd0, 5'd2, c2[31:16])); // r2 = c2
		emit(encI(isaPkg::opOri, 5'd2, 5'd2, c2[15:0]));
		foreach (rOps[k]) begin
			emit(encR(rOps[k], 5'd1, 5'd2, 5'd3));
			storeReg(5'd3, refR(rOps[k], c1, c2));
		end
		foreach (iOps[k]) begin
			drawWord(w);
			emit(encI(iOps[k], 5'd1, 5'd3, w[31:16]));
			storeReg(5'd3, refI(iOps[k], c1, w[31:16]));
		end
		// Reload the ADD result, double it, store again
		emit(encI(isaPkg::opLw, 5'd0, 5'd4, 16'(dataBase)));
		emit(encR(isaPkg::fnAddu, 5'd4, 5'd4, 5'd5));
		storeReg(5'd5, expWord[dataBase / 4] + expWord[dataBase / 4]);
		emit(encR(isaPkg::fnAddu, 5'd1, 5'd2, 5'd0)); // Dropped write to r0
		storeReg(5'd0, 32'h0);
		for (int i = 0; i < words; i++) begin
			if (i < progWords.size()) i_wbMemory.mem[i] = progWords[i];
			else i_wbMemory.mem[i] = 32'hFC00_0000 | (i << 2); // Unknown opcode
		end
		cycleLimit = progWords.size() * (7 + 2 * 3) + 100 + resetCycles;
		repeat (resetCycles) @(posedge CLK);
		reset <= 1'b0;
		wait (storesSeen == numStores);
		@(posedge CLK); // Last store's check runs first
		$display("TESTBENCH PASSED");
		$finish;
	end

	always @(posedge CLK) begin
		rngState = lcgNext(rngState);
		waitCycles <= rngState[17:16]; // 0 to 3 waits
	end

	// Bus history for the checks
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		resetSeen <= reset;
		prevAdr <= wbReq.adr;
		prevWe <= wbReq.we;
		prevDatW <= wbReq.datW;
		if (reset) begin
			nextFetch <= '0;
		end else if (wbRsp.ack && !wbReq.we && !wbReq.adr[topBit]) begin
			nextFetch <= wbReq.adr + uarchPkg::addrT'(4); // Fetch acked
		end
		if (!reset && wbRsp.ack && wbReq.we) storesSeen <= storesSeen + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: only %0d of %0d stores seen after %0d cycles",
				storesSeen, numStores, cycleCount);
			abortRun();
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	resetQuiet: assert property (@(posedge CLK)
		(cycleCount != 0 && (reset || resetSeen)) |-> !(wbReq.cyc || wbReq.stb || wbReq.we))
		else begin
			$display("[ERROR] wbReq.cyc/stb/we near reset: cyc %h stb %h we %h",
				$sampled(wbReq.cyc), $sampled(wbReq.stb), $sampled(wbReq.we));
			abortRun();
		end

	fetchOrder: assert property (@(posedge CLK) disable iff (reset)
		(wbReq.stb && !wbReq.we && !wbReq.adr[topBit]) |-> (wbReq.adr == nextFetch))
		else begin
			$display("[ERROR] wbReq.adr fetch: got %h, expected %h",
				$sampled(wbReq.adr), $sampled(nextFetch));
			abortRun();
		end

	storeCheck: assert property (@(posedge CLK) disable iff (reset)
		(wbReq.stb && wbReq.we && wbRsp.ack) |-> (expNowValid && wbReq.datW == expNow))
		else begin
			$display("[ERROR] wbReq.datW at adr %h: got %h, expected %h, planned %h",
				$sampled(wbReq.adr), $sampled(wbReq.datW), $sampled(expNow),
				$sampled(expNowValid));
			abortRun();
		end

	holdRequest: assert property (@(posedge CLK) disable iff (reset)
		(wbReq.stb && !wbRsp.ack) |=> (wbReq.stb && wbReq.adr == prevAdr &&
		wbReq.we == prevWe && wbReq.datW == prevDatW))
		else begin
			$display("[ERROR] wbReq changed in wait: stb %h adr %h->%h we %h->%h datW %h->%h",
				$sampled(wbReq.stb), $sampled(prevAdr), $sampled(wbReq.adr),
				$sampled(prevWe), $sampled(wbReq.we), $sampled(prevDatW),
				$sampled(wbReq.datW));
			abortRun();
		end

endmodule

`default_nettype wire

//--- bench/wbMemory.sv
`timescale 1ns/1ns
`default_nettype none

module wbMemory (
	input logic CLK,
	input logic reset,
	input logic [1:0] waitCycles, // Wait states for a new transfer
	input uarchPkg::wbReqT wbReq,
	output uarchPkg::wbRspT wbRsp
);

	localparam int words = uarchPkg::memBytes / 4;

	isaPkg::wordT mem [words]; // Filled by the testbench
	isaPkg::wordT datR;
	logic ack;
	logic busy; // Transfer under way, counting waits
	logic [1:0] waitLeft;
	logic [1:0] waitNow;
	logic [uarchPkg::addrWidth-3:0] wordIdx;

	assign wordIdx = wbReq.adr[uarchPkg::addrWidth-1:2]; // Low two bits ignored
	assign waitNow = busy ? waitLeft : waitCycles; // Delay latched at start

	always @(posedge CLK) begin
		if (reset) begin
			ack <= 1'b0;
			busy <= 1'b0;
			waitLeft <= 2'd0;
		end else if (ack) begin
			ack <= 1'b0; // Single-cycle ack
			busy <= 1'b0;
		end else if (wbReq.cyc && wbReq.stb) begin
			if (waitNow == 2'd0) begin
				ack <= 1'b1;
				datR <= mem[wordIdx]; // Read data with ack
				if (wbReq.we) mem[wordIdx] <= wbReq.datW;
			end else begin
				busy <= 1'b1;
				waitLeft <= waitNow - 2'd1;
			end
		end
	end

	assign wbRsp.ack = ack;
	assign wbRsp.datR = datR;

endmodule

`default_nettype wire

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

	typedef logic [4:0] regAddrT; // Register index
	typedef logic [31:0] wordT; // Data word

	//////////////////////////////////////////////////////////////////////
	// Opcode and function fields
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		opSpecial = 6'b000000, // R-type, funct decides
		opAddi = 6'b001000,
		opAddiu = 6'b001001,
		opSlti = 6'b001010,
		opSltiu = 6'b001011,
		opAndi = 6'b001100, // Zero-extended imm
		opOri = 6'b001101, // Zero-extended imm
		opXori = 6'b001110, // Zero-extended imm
		opLui = 6'b001111,
		opLw = 6'b100011,
		opSw = 6'b101011
	} opcodeT;

	typedef enum logic [5:0] {
		fnSllv = 6'b000100, // Variable shifts, amount in rs
		fnSrlv = 6'b000110,
		fnSrav = 6'b000111,
		fnAdd = 6'b100000,
		fnAddu = 6'b100001, // No overflow trap in this core
		fnSub = 6'b100010,
		fnSubu = 6'b100011,
		fnAnd = 6'b100100,
		fnOr = 6'b100101,
		fnXor = 6'b100110,
		fnNor = 6'b100111,
		fnSlt = 6'b101010,
		fnSltu = 6'b101011
	} functT;

	//////////////////////////////////////////////////////////////////////
	// Instruction formats
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		opcodeT opcode; // [31:26]
		regAddrT rs; // [25:21]
		regAddrT rt; // [20:16]
		regAddrT rd; // [15:11]
		logic [4:0] shamt; // Unused by the kept shifts
		functT funct; // [5:0]
	} rTypeT;

	typedef struct packed {
		opcodeT opcode;
		regAddrT rs; // Base or source
		regAddrT rt; // Destination, store data for SW
		logic [15:0] imm16;
	} iTypeT;

	typedef union packed {
		rTypeT r; // Register view
		iTypeT i; // Immediate view
	} instrT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluNor,
		aluXor,
		aluSlt, // Signed compare
		aluSltu, // Unsigned compare
		aluSll,
		aluSrl,
		aluSra,
		aluLui // b moved to upper half
	} aluOpT;

endpackage

`default_nettype wire

//--- common/uarchPkg.sv
`default_nettype none

package uarchPkg;

	localparam int addrWidth = 9; // Byte address, 512-byte space
	localparam int memBytes = 1 << addrWidth; // Size of the bus memory
	localparam int pcStep = 4; // One word per instruction

	typedef logic [addrWidth-1:0] addrT;

	//////////////////////////////////////////////////////////////////////
	// Control word from the FSM to the datapath
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic irLd; // Capture fetched word
		logic pcInc; // PC += pcStep
		logic regW; // Register file write
		logic regInSel; // 0 ALU result, 1 load data
		logic regDstSel; // 0 rt, 1 rd
		logic aluSrcSel; // 0 register B, 1 immediate
		logic zeroExt; // Logic immediates
		isaPkg::aluOpT aluOp;
		logic busReq; // Start a bus cycle
		logic busWe; // Store
		logic addrSel; // 0 PC, 1 ALU result
	} ctrlWordT;

	//////////////////////////////////////////////////////////////////////
	// Wishbone classic master signals
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addrT adr; // Low two bits ignored by slave
		isaPkg::wordT datW;
	} wbReqT;

	typedef struct packed {
		logic ack; // One cycle per transfer
		isaPkg::wordT datR;
	} wbRspT;

endpackage

`default_nettype wire

//--- control/controlUnit.sv
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
	input logic CLK,
	input logic reset,
	input isaPkg::instrT instr,
	input logic busDone,
	output uarchPkg::ctrlWordT ctrl
);

	typedef enum logic [3:0] {
		sFetch,
		sFetchDone,
		sDecode,
		sExecute,
		sWriteback,
		sMemRead,
		sLoadWb,
		sMemWrite
	} stateT;

	stateT state;
	stateT nextState;
	isaPkg::aluOpT decOp; // Decoded ALU operation
	logic decImm; // Immediate operand
	logic decZeroExt;
	logic decRd; // R-type writes rd
	logic decAlu; // Known ALU instruction
	logic decLoad;
	logic decStore;

	//////////////////////////////////////////////////////////////////////
	// Instruction decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		decOp = isaPkg::aluAdd;
		decImm = 1'b1;
		decZeroExt = 1'b0;
		decRd = 1'b0;
		decAlu = 1'b1;
		decLoad = 1'b0;
		decStore = 1'b0;
		case (instr.i.opcode)
			isaPkg::opSpecial: begin
				decImm = 1'b0; // Register B operand
				decRd = 1'b1;
				case (instr.r.funct)
					isaPkg::fnAdd, isaPkg::fnAddu: decOp = isaPkg::aluAdd;
					isaPkg::fnSub, isaPkg::fnSubu: decOp = isaPkg::aluSub;
					isaPkg::fnAnd: decOp = isaPkg::aluAnd;
					isaPkg::fnOr: decOp = isaPkg::aluOr;
					isaPkg::fnNor: decOp = isaPkg::aluNor;
					isaPkg::fnXor: decOp = isaPkg::aluXor;
					isaPkg::fnSlt: decOp = isaPkg::aluSlt;
					isaPkg::fnSltu: decOp = isaPkg::aluSltu;
					isaPkg::fnSllv: decOp = isaPkg::aluSll;
					isaPkg::fnSrlv: decOp = isaPkg::aluSrl;
					isaPkg::fnSrav: decOp = isaPkg::aluSra;
					default: decAlu = 1'b0; // Unknown funct, no write
				endcase
			end
			isaPkg::opAddi, isaPkg::opAddiu: decOp = isaPkg::aluAdd;
			isaPkg::opSlti: decOp = isaPkg::aluSlt;
			isaPkg::opSltiu: decOp = isaPkg::aluSltu; // Sign-extended, compared unsigned
			isaPkg::opAndi: begin
				decOp = isaPkg::aluAnd;
				decZeroExt = 1'b1;
			end
			isaPkg::opOri: begin
				decOp = isaPkg::aluOr;
				decZeroExt = 1'b1;
			end
			isaPkg::opXori: begin
				decOp = isaPkg::aluXor;
				decZeroExt = 1'b1;
			end
			isaPkg::opLui: decOp = isaPkg::aluLui;
			isaPkg::opLw: begin
				decAlu = 1'b0;
				decLoad = 1'b1; // Effective address via add
			end
			isaPkg::opSw: begin
				decAlu = 1'b0;
				decStore = 1'b1;
			end
			default: decAlu = 1'b0;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// State register and next state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (reset) begin
			state <= sFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			sFetch: if (busDone) nextState = sFetchDone; // Wait for ack
			sFetchDone: nextState = sDecode;
			sDecode: nextState = sExecute;
			sExecute: begin
				if (decLoad) nextState = sMemRead;
				else if (decStore) nextState = sMemWrite;
				else if (decAlu) nextState = sWriteback;
				else nextState = sFetch; // Unknown, skip
			end
			sWriteback: nextState = sFetch;
			sMemRead: if (busDone) nextState = sLoadWb;
			sLoadWb: nextState = sFetch;
			sMemWrite: if (busDone) nextState = sFetch;
			default: nextState = sFetch;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control word
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		ctrl = '0;
		if (state != sFetch && state != sFetchDone) begin // IR valid from decode on
			ctrl.aluOp = decOp;
			ctrl.aluSrcSel = decImm;
			ctrl.zeroExt = decZeroExt;
			ctrl.regDstSel = decRd;
		end
		case (state)
			sFetch: ctrl.busReq = 1'b1; // addrSel 0, PC
			sFetchDone: begin
				ctrl.irLd = 1'b1;
				ctrl.pcInc = 1'b1;
			end
			sWriteback: ctrl.regW = 1'b1;
			sMemRead: begin
				ctrl.busReq = 1'b1;
				ctrl.addrSel = 1'b1;
			end
			sLoadWb: begin
				ctrl.regW = 1'b1;
				ctrl.regInSel = 1'b1; // Load data to rt
			end
			sMemWrite: begin
				ctrl.busReq = 1'b1;
				ctrl.busWe = 1'b1;
				ctrl.addrSel = 1'b1;
			end
			default: ctrl.busReq = 1'b0; // Decode, execute only steer the ALU
		endcase
	end

	legalState: assert property (@(posedge CLK) disable iff (reset)
		state inside {sFetch, sFetchDone, sDecode, sExecute,
			sWriteback, sMemRead, sLoadWb, sMemWrite});

endmodule

`default_nettype wire

//--- files.f
common/isaPkg.sv
common/uarchPkg.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/busMaster.sv
control/controlUnit.sv
rtl/mipsCore.sv
bench/wbMemory.sv
bench/mipsCoreTb.sv

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input isaPkg::aluOpT op,
	input isaPkg::wordT a,
	input isaPkg::wordT b,
	input logic shamtSrc, // 1 amount from a, 0 fixed 16 for LUI
	output isaPkg::wordT result
);

	logic [4:0] shiftAmt;
	logic sltSigned;
	logic sltUnsigned;

	assign shiftAmt = shamtSrc ? a[4:0] : 5'd16; // SLLV style, b shifted by a
	assign sltSigned = $signed(a) < $signed(b);
	assign sltUnsigned = a < b;

	//////////////////////////////////////////////////////////////////////
	// Operation select
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (op)
			isaPkg::aluAdd: result = a + b; // ADD, ADDI, address calc
			isaPkg::aluSub: result = a - b;
			isaPkg::aluAnd: result = a & b;
			isaPkg::aluOr: result = a | b;
			isaPkg::aluNor: result = ~(a | b);
			isaPkg::aluXor: result = a ^ b;
			isaPkg::aluSlt: result = {31'b0, sltSigned};
			isaPkg::aluSltu: result = {31'b0, sltUnsigned};
			isaPkg::aluSll, isaPkg::aluLui: result = b << shiftAmt; // LUI is b << 16
			isaPkg::aluSrl: result = b >> shiftAmt;
			isaPkg::aluSra: result = isaPkg::wordT'($signed(b) >>> shiftAmt);
			default: result = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/busMaster.sv
`timescale 1ns/1ns
`default_nettype none

module busMaster (
	input logic CLK,
	input logic reset,
	input logic req, // Level from the FSM
	input logic we,
	input uarchPkg::addrT addr,
	input isaPkg::wordT wrData,
	output uarchPkg::wbReqT wbReq,
	input uarchPkg::wbRspT wbRsp,
	output isaPkg::wordT rdData,
	output logic done
);

	logic cyc; // Cycle in flight
	logic weQ;
	logic start;
	uarchPkg::addrT adrQ;
	isaPkg::wordT datQ;

	assign start = req && !cyc; // Next request only once cyc has dropped
	assign done = cyc && wbRsp.ack; // Same cycle as ack

	always_ff @(posedge CLK) begin
		if (reset) begin
			cyc <= 1'b0;
			weQ <= 1'b0;
		end else if (done) begin
			cyc <= 1'b0; // Drop after ack
			weQ <= 1'b0;
		end else if (start) begin
			cyc <= 1'b1;
			weQ <= we;
		end
	end

	// Request payload held until ack
	always_ff @(posedge CLK) begin
		if (start) begin
			adrQ <= addr;
			datQ <= wrData;
		end
		if (done) rdData <= wbRsp.datR; // Registered read data
	end

	assign wbReq.cyc = cyc;
	assign wbReq.stb = cyc; // Classic, no pipelining
	assign wbReq.we = weQ;
	assign wbReq.adr = adrQ;
	assign wbReq.datW = datQ;

	reqStable: assert property (@(posedge CLK) disable iff (reset)
		(wbReq.stb && !wbRsp.ack) |=>
		($stable(wbReq.adr) && $stable(wbReq.we) && $stable(wbReq.datW)));

endmodule

`default_nettype wire

//--- rtl/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
	input logic CLK,
	input logic reset,
	output uarchPkg::wbReqT wbReq,
	input uarchPkg::wbRspT wbRsp
);

	uarchPkg::ctrlWordT ctrl;
	uarchPkg::addrT pc;
	uarchPkg::addrT busAddr;
	isaPkg::instrT ir; // Instruction register
	isaPkg::wordT rdDataA;
	isaPkg::wordT rdDataB;
	isaPkg::wordT immExt;
	isaPkg::wordT aluB;
	isaPkg::wordT aluResult;
	isaPkg::wordT aluOut; // Registered ALU result
	isaPkg::wordT loadData; // Fetched word or load data
	isaPkg::wordT regWrData;
	isaPkg::regAddrT regWrAddr;
	logic shamtSrc;
	logic busDone;

	//////////////////////////////////////////////////////////////////////
	// PC, IR and ALU result registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (reset) begin
			pc <= '0;
		end else if (ctrl.pcInc) begin
			pc <= pc + uarchPkg::addrT'(uarchPkg::pcStep);
		end
	end

	always_ff @(posedge CLK) begin
		if (ctrl.irLd) ir <= loadData; // Word captured on fetch ack
		aluOut <= aluResult; // Stable once operands settle
	end

	//////////////////////////////////////////////////////////////////////
	// Operand and destination muxes
	//////////////////////////////////////////////////////////////////////

	assign immExt = ctrl.zeroExt ? {16'b0, ir.i.imm16} :
		{{16{ir.i.imm16[15]}}, ir.i.imm16};
	assign aluB = ctrl.aluSrcSel ? immExt : rdDataB;
	assign shamtSrc = ctrl.aluOp != isaPkg::aluLui; // LUI shifts by 16
	assign regWrAddr = ctrl.regDstSel ? ir.r.rd : ir.r.rt;
	assign regWrData = ctrl.regInSel ? loadData : aluOut;
	assign busAddr = ctrl.addrSel ? aluOut[uarchPkg::addrWidth-1:0] : pc;

	controlUnit i_controlUnit (
		.CLK(CLK),
		.reset(reset),
		.instr(ir),
		.busDone(busDone),
		.ctrl(ctrl)
	);

	registerFile i_registerFile (
		.CLK(CLK),
		.reset(reset),
		.rdAddrA(ir.r.rs),
		.rdAddrB(ir.r.rt),
		.wrAddr(regWrAddr),
		.wrData(regWrData),
		.wrEn(ctrl.regW),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	alu i_alu (
		.op(ctrl.aluOp),
		.a(rdDataA),
		.b(aluB),
		.shamtSrc(shamtSrc),
		.result(aluResult)
	);

	busMaster i_busMaster (
		.CLK(CLK),
		.reset(reset),
		.req(ctrl.busReq),
		.we(ctrl.busWe),
		.addr(busAddr),
		.wrData(rdDataB), // SW stores rt
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.rdData(loadData),
		.done(busDone)
	);

	// PC only ever moves by whole words
	pcAligned: assert property (@(posedge CLK) disable iff (reset)
		ctrl.pcInc |=> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
	input logic CLK,
	input logic reset,
	input isaPkg::regAddrT rdAddrA,
	input isaPkg::regAddrT rdAddrB,
	input isaPkg::regAddrT wrAddr,
	input isaPkg::wordT wrData,
	input logic wrEn,
	output isaPkg::wordT rdDataA,
	output isaPkg::wordT rdDataB
);

	isaPkg::wordT regs [32]; // GPRs, r0 included

	// Write port, r0 never written so it reads zero
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	always_ff @(posedge CLK) begin
		rdDataA <= regs[rdAddrA]; // One cycle after address
		rdDataB <= regs[rdAddrB];
	end

endmodule

`default_nettype wire
